//--- Makefile
TOP := core_tb

.PHONY: all lint clean

all:
	verilator --binary --assert --timing --top-module $(TOP) -Mdir obj_dir -f files.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --assert --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

//--- bench/core_checker.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------
// Bound port assertions for the GPU slice
// ----------------------------------------

module core_checker
    import gpu_pkg::*;
#(
    parameter int WARP_CNT    = NUM_WARPS,
    parameter int MEM_LATENCY = 3
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [WARP_CNT-1:0]  warp_req,
    input  wire logic [WARP_CNT-1:0]  warp_mem,
    input  wire logic                 mem_stall,
    input  wire logic                 issue_valid,
    input  wire wid_t                 issue_wid,
    input  wire lane_e                issue_lane,
    input  wire logic [NUM_LANES-1:0] retire,
    input  wire logic                 empty,
    input  wire logic                 alm_empty
);

    logic [WARP_CNT-1:0] req_q;
    logic [WARP_CNT-1:0] mem_q;
    int                  stall_run;
    int                  fail_count = 0;

    // Requests as seen by the scheduler one edge earlier
    always_ff @(posedge clk) begin
        req_q <= warp_req;
        mem_q <= warp_mem;
    end

    // Number of edges in a row at which the memory lane was held
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_run <= 0;
        end else if (mem_stall) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    reset_values: assert property (@(posedge clk)
        $fell(reset) |-> empty && !alm_empty && !issue_valid && (retire == '0))
        else begin
            $error("outputs left their reset values right after reset");
            fail_count++;
        end

    issue_requested: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> req_q[issue_wid])
        else begin
            $error("a warp issued without a pending request");
            fail_count++;
        end

    issue_lane_match: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> (issue_lane == lane_e'(mem_q[issue_wid])))
        else begin
            $error("issued lane differs from the requested lane");
            fail_count++;
        end

    no_retire_when_empty: assert property (@(posedge clk) disable iff (reset)
        empty |-> (retire == '0))
        else begin
            $error("a lane retired while the core reported empty");
            fail_count++;
        end

    stall_holds_mem: assert property (@(posedge clk) disable iff (reset)
        (stall_run > MEM_LATENCY) |-> !retire[LANE_MEM])
        else begin
            $error("memory lane retired during a long stall");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- bench/core_tb.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------
// Testbench for the GPU issue slice with
// a reference model of issue and retire
// ----------------------------------------

module core_tb
    import gpu_pkg::*;
();

    localparam int WARP_CNT     = NUM_WARPS;
    localparam int QUEUE_DEPTH  = 8;
    localparam int MEM_LATENCY  = 3;
    localparam int ALM_EMPTY    = 1;
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 600;
    localparam int TAIL_CYCLES  = 32;
    localparam int DRAIN_LIMIT  = QUEUE_DEPTH + MEM_LATENCY + 2;
    localparam int BURST_CYCLES = 40;
    localparam int SETTLE_LIMIT = 4 * (QUEUE_DEPTH + MEM_LATENCY);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 + RAND_CYCLES + TAIL_CYCLES +
                                     DRAIN_LIMIT + BURST_CYCLES + SETTLE_LIMIT + 50;

    logic                 clk;
    logic                 reset;
    logic [WARP_CNT-1:0]  warp_req;
    logic [WARP_CNT-1:0]  warp_mem;
    logic                 mem_stall;
    wid_t                 probe_wid;
    logic                 issue_valid;
    wid_t                 issue_wid;
    lane_e                issue_lane;
    logic [NUM_LANES-1:0] retire;
    wid_t [NUM_LANES-1:0] retire_wid;
    logic                 empty;
    logic                 alm_empty;

    logic [31:0] rng;
    int          errors;
    int          test_start;
    bit          checking;
    int          stall_hold;
    int          stall_run;
    int          last_issued;
    int          model_cnt [WARP_CNT];
    // Issued entries in order, each one {lane, wid}
    logic [2:0]  issued_q [$];

    gpu_core_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .warp_req    (warp_req),
        .warp_mem    (warp_mem),
        .mem_stall   (mem_stall),
        .probe_wid   (probe_wid),
        .issue_valid (issue_valid),
        .issue_wid   (issue_wid),
        .issue_lane  (issue_lane),
        .retire      (retire),
        .retire_wid  (retire_wid),
        .empty       (empty),
        .alm_empty   (alm_empty)
    );

    bind gpu_core_top core_checker #(
        .WARP_CNT    (WARP_CNT),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_core_checker (
        .clk         (clk),
        .reset       (reset),
        .warp_req    (warp_req),
        .warp_mem    (warp_mem),
        .mem_stall   (mem_stall),
        .issue_valid (issue_valid),
        .issue_wid   (issue_wid),
        .issue_lane  (issue_lane),
        .retire      (retire),
        .empty       (empty),
        .alm_empty   (alm_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Error at %0t ns: watchdog expired before the tests finished", $time);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // First requesting warp after the last issued one, or -1 if none asks
    function automatic int rr_pick(input logic [WARP_CNT-1:0] req, input int last);
        int idx;
        for (int k = 1; k <= WARP_CNT; k++) begin
            idx = (last + k) % WARP_CNT;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // Value check errors plus assertion failures in the bound checker
    function automatic int total_errors();
        return errors + i_dut.i_core_checker.fail_count;
    endfunction

    task automatic expect_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
    endtask

    // Runs at the falling edge, before new inputs are driven, so the
    // inputs still hold what the last rising edge sampled
    task automatic check_cycle();
        int         pick;
        int         all_zero;
        logic [2:0] head;
        all_zero = 1;
        for (int w = 0; w < WARP_CNT; w++) begin
            if (model_cnt[w] != 0) begin
                all_zero = 0;
            end
        end
        // Flags follow the counts of the strobes seen one cycle earlier
        expect_value("empty", all_zero, int'(empty));
        expect_value("alm_empty", int'(model_cnt[probe_wid] == ALM_EMPTY), int'(alm_empty));
        stall_run = mem_stall ? stall_run + 1 : 0;
        if (stall_run > MEM_LATENCY) begin
            expect_value("retire[LANE_MEM]", 0, int'(retire[LANE_MEM]));
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (retire[l]) begin
                if (issued_q.size() == 0) begin
                    report_error($sformatf("lane %0d retired with nothing outstanding", l));
                end else begin
                    head = issued_q.pop_front();
                    expect_value("retire lane of oldest entry", int'(head[2]), l);
                    expect_value($sformatf("retire_wid[%0d]", l), int'(head[1:0]),
                                 int'(retire_wid[l]));
                    model_cnt[head[1:0]]--;
                end
            end
        end
        if (issue_valid) begin
            pick = rr_pick(warp_req, last_issued);
            if (pick < 0) begin
                report_error("an instruction issued while no warp was requesting");
            end else begin
                expect_value("issue_wid", pick, int'(issue_wid));
                expect_value("issue_lane", int'(warp_mem[pick]), int'(issue_lane));
            end
            last_issued = int'(issue_wid);
            issued_q.push_back({issue_lane, issue_wid});
            model_cnt[issue_wid]++;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        if (checking) begin
            check_cycle();
        end
    endtask

    task automatic run_random(input int cycles, input bit with_stall, input bit alu_only);
        for (int c = 0; c < cycles; c++) begin
            tick();
            rng = xorshift(rng);
            warp_req  = rng[WARP_CNT-1:0];
            warp_mem  = alu_only ? '0 : rng[2*WARP_CNT-1:WARP_CNT];
            probe_wid = rng[9:8];
            // Stalls come in runs of one to eight cycles
            if (with_stall && stall_hold > 0) begin
                stall_hold--;
                mem_stall = 1'b1;
            end else if (with_stall && rng[15:12] == 4'h0) begin
                stall_hold = int'(rng[18:16]);
                mem_stall  = 1'b1;
            end else begin
                stall_hold = 0;
                mem_stall  = 1'b0;
            end
        end
    endtask

    task automatic wait_drained(input int limit, input string what);
        int n;
        n = 0;
        while (!(empty && issued_q.size() == 0) && n < limit) begin
            tick();
            n++;
        end
        if (!(empty && issued_q.size() == 0)) begin
            report_error($sformatf("%s did not empty the core within %0d cycles", what, limit));
        end
    endtask

    task automatic end_test(input string name);
        int total;
        total = total_errors();
        $display("Test %s: %0d errors", name, total - test_start);
        test_start = total;
    endtask

    initial begin
        wid_t burst_wid;
        rng         = 32'h3e0d7a36;
        errors      = 0;
        test_start  = 0;
        checking    = 1'b0;
        stall_hold  = 0;
        stall_run   = 0;
        last_issued = WARP_CNT - 1;
        for (int w = 0; w < WARP_CNT; w++) begin
            model_cnt[w] = 0;
        end
        reset     = 1'b1;
        warp_req  = '0;
        warp_mem  = '0;
        mem_stall = 1'b0;
        probe_wid = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        expect_value("empty", 1, int'(empty));
        expect_value("alm_empty", 0, int'(alm_empty));
        expect_value("issue_valid", 0, int'(issue_valid));
        expect_value("retire", 0, int'(retire));
        checking = 1'b1;
        end_test("reset check");

        run_random(RAND_CYCLES, 1'b1, 1'b0);
        // A stall-free ALU tail flushes the memory work out of the queue
        run_random(TAIL_CYCLES, 1'b0, 1'b1);
        end_test("random traffic with stalls");

        tick();
        warp_req  = '0;
        warp_mem  = '0;
        mem_stall = 1'b0;
        wait_drained(DRAIN_LIMIT, "drain");
        end_test("drain with no requests");

        tick();
        rng       = xorshift(rng);
        burst_wid = rng[1:0];
        for (int c = 0; c < BURST_CYCLES; c++) begin
            tick();
            rng       = xorshift(rng);
            warp_req  = WARP_CNT'(1) << burst_wid;
            warp_mem  = rng[WARP_CNT-1:0];
            probe_wid = burst_wid;
            mem_stall = 1'b0;
        end
        tick();
        warp_req = '0;
        wait_drained(SETTLE_LIMIT, "burst");
        end_test("burst on a single warp");

        $display("Summary: 4 tests run, %0d errors", total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/gpu_pkg.sv
hw/warp_issue.sv
hw/issue_queue.sv
hw/exec_lanes.sv
hw/pending_instr.sv
hw/gpu_core_top.sv
bench/core_checker.sv
bench/core_tb.sv

//--- hw/exec_lanes.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------
// ALU and memory retire lanes
// ----------------------------------------

module exec_lanes
    import gpu_pkg::*;
#(
    parameter int MEM_LATENCY = 3
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 q_valid,
    input  wire wid_t                 q_wid,
    input  wire lane_e                q_lane,
    input  wire logic                 mem_stall,
    output logic                      q_pop,
    output logic [NUM_LANES-1:0]      retire,
    output wid_t [NUM_LANES-1:0]      retire_wid
);

    logic                   alu_v;
    wid_t                   alu_wid;
    logic [MEM_LATENCY-1:0] mem_v;
    wid_t                   mem_wid [MEM_LATENCY];
    logic                   mem_busy;
    logic                   alu_pop;
    logic                   mem_pop;

    // Memory work that retires after this cycle, an ALU op must not pass it
    always_comb begin
        mem_busy = 1'b0;
        for (int i = 0; i < MEM_LATENCY - 1; i++) begin
            mem_busy = mem_busy | mem_v[i];
        end
    end

    // Heads are taken in queue order, so a blocked head blocks all behind it
    assign alu_pop = q_valid && (q_lane == LANE_ALU) && !mem_busy;
    assign mem_pop = q_valid && (q_lane == LANE_MEM) && !mem_stall;
    assign q_pop   = alu_pop || mem_pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_v <= 1'b0;
        end else begin
            alu_v <= alu_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_pop) begin
            alu_wid <= q_wid;
        end
    end

    // Memory pipeline freezes under stall. Its last stage drops so that
    // each retire strobe lasts one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_v <= '0;
        end else if (!mem_stall) begin
            for (int i = MEM_LATENCY - 1; i > 0; i--) begin
                mem_v[i] <= mem_v[i-1];
            end
            mem_v[0] <= mem_pop;
        end else begin
            mem_v[MEM_LATENCY-1] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            for (int i = MEM_LATENCY - 1; i > 0; i--) begin
                mem_wid[i] <= mem_wid[i-1];
            end
            mem_wid[0] <= q_wid;
        end
    end

    assign retire[LANE_ALU]     = alu_v;
    assign retire_wid[LANE_ALU] = alu_wid;
    assign retire[LANE_MEM]     = mem_v[MEM_LATENCY-1];
    assign retire_wid[LANE_MEM] = mem_wid[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- hw/gpu_core_top.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------
// GPU core issue and retire tracking slice
// ----------------------------------------

module gpu_core_top
    import gpu_pkg::*;
#(
    parameter int WARP_CNT    = NUM_WARPS,
    parameter int QUEUE_DEPTH = 8,
    parameter int MEM_LATENCY = 3,
    parameter int ALM_EMPTY   = 1
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [WARP_CNT-1:0]  warp_req,
    input  wire logic [WARP_CNT-1:0]  warp_mem,
    input  wire logic                 mem_stall,
    input  wire wid_t                 probe_wid,
    output logic                      issue_valid,
    output wid_t                      issue_wid,
    output lane_e                     issue_lane,
    output logic [NUM_LANES-1:0]      retire,
    output wid_t [NUM_LANES-1:0]      retire_wid,
    output logic                      empty,
    output logic                      alm_empty
);

    logic  queue_full;
    logic  q_valid;
    wid_t  q_wid;
    lane_e q_lane;
    logic  q_pop;

    warp_issue #(
        .WARP_CNT (WARP_CNT)
    ) i_warp_issue (
        .clk         (clk),
        .reset       (reset),
        .warp_req    (warp_req),
        .warp_mem    (warp_mem),
        .queue_full  (queue_full),
        .issue_valid (issue_valid),
        .issue_wid   (issue_wid),
        .issue_lane  (issue_lane)
    );

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_issue_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (issue_valid),
        .push_wid  (issue_wid),
        .push_lane (issue_lane),
        .pop       (q_pop),
        .full      (queue_full),
        .q_valid   (q_valid),
        .q_wid     (q_wid),
        .q_lane    (q_lane)
    );

    exec_lanes #(
        .MEM_LATENCY (MEM_LATENCY)
    ) i_exec_lanes (
        .clk        (clk),
        .reset      (reset),
        .q_valid    (q_valid),
        .q_wid      (q_wid),
        .q_lane     (q_lane),
        .mem_stall  (mem_stall),
        .q_pop      (q_pop),
        .retire     (retire),
        .retire_wid (retire_wid)
    );

    pending_instr #(
        .WARP_CNT  (WARP_CNT),
        .ALM_EMPTY (ALM_EMPTY)
    ) i_pending_instr (
        .clk           (clk),
        .reset         (reset),
        .incr          (issue_valid),
        .incr_wid      (issue_wid),
        .decr          (retire),
        .decr_wid      (retire_wid),
        .alm_empty_wid (probe_wid),
        .empty         (empty),
        .alm_empty     (alm_empty)
    );

endmodule

`default_nettype wire

//--- hw/gpu_pkg.sv
`default_nettype none
// ----------------------------------------
// Shared types for the GPU issue slice
// ----------------------------------------

package gpu_pkg;

    // Default warp count of the core
    localparam int NUM_WARPS = 4;

    // Warp id, wide enough for NUM_WARPS
    typedef logic [1:0] wid_t;

    // Default width of a pending instruction counter
    localparam int CTR_BITS = 6;
    typedef logic [CTR_BITS-1:0] ctr_t;

    // Retire lane of an instruction
    typedef enum logic {
        LANE_ALU = 1'b0,
        LANE_MEM = 1'b1
    } lane_e;

    // One retire strobe per lane_e value
    localparam int NUM_LANES = 2;

endpackage

`default_nettype wire

//--- hw/issue_queue.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------
// Issue queue of warp ids and lane bits
// ----------------------------------------

module issue_queue
    import gpu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  push,
    input  wire wid_t  push_wid,
    input  wire lane_e push_lane,
    input  wire logic  pop,
    output logic       full,
    output logic       q_valid,
    output wid_t       q_wid,
    output lane_e      q_lane
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    wid_t  wid_mem  [QUEUE_DEPTH];
    lane_e lane_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_pop  = pop && (count != '0);
    assign do_push = push && ((count != CNT_W'(QUEUE_DEPTH)) || do_pop);

    // The issue stage is registered, so a push already on its way counts
    // against the last free slot
    assign full = (count == CNT_W'(QUEUE_DEPTH)) ||
                  (push && (count == CNT_W'(QUEUE_DEPTH - 1)));

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            wid_mem[wr_ptr]  <= push_wid;
            lane_mem[wr_ptr] <= push_lane;
        end
    end

    // Head entry is visible without a read cycle
    assign q_valid = (count != '0);
    assign q_wid   = wid_mem[rd_ptr];
    assign q_lane  = lane_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/pending_instr.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------
// Pending instruction counters per warp
// ----------------------------------------

module pending_instr
    import gpu_pkg::*;
#(
    parameter int WARP_CNT  = NUM_WARPS,
    parameter int CTR_WIDTH = $bits(ctr_t),
    parameter int ALM_EMPTY = 1
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  incr,
    input  wire wid_t                  incr_wid,
    input  wire logic [NUM_LANES-1:0]  decr,
    input  wire wid_t [NUM_LANES-1:0]  decr_wid,
    input  wire wid_t                  alm_empty_wid,
    output logic                       empty,
    output logic                       alm_empty
);

    localparam int DEC_W = $clog2(NUM_LANES + 1);

    logic [WARP_CNT-1:0] zero_r;
    logic [WARP_CNT-1:0] alm_r;

    for (genvar w = 0; w < WARP_CNT; w++) begin : g_warp
        logic [CTR_WIDTH-1:0] count;
        logic [CTR_WIDTH-1:0] count_n;
        logic [DEC_W-1:0]     n_dec;
        logic                 n_inc;

        // Both lanes may retire the same warp in one cycle
        always_comb begin
            n_dec = '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (decr[l] && (decr_wid[l] == wid_t'(w))) begin
                    n_dec = n_dec + 1'b1;
                end
            end
            n_inc   = incr && (incr_wid == wid_t'(w));
            count_n = count + CTR_WIDTH'(n_inc) - CTR_WIDTH'(n_dec);
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                count     <= '0;
                zero_r[w] <= 1'b1;
                alm_r[w]  <= 1'b0;
            end else begin
                count     <= count_n;
                zero_r[w] <= (count_n == '0);
                alm_r[w]  <= (count_n == CTR_WIDTH'(ALM_EMPTY));
            end
        end
    end

    assign empty     = &zero_r;
    assign alm_empty = alm_r[alm_empty_wid];

endmodule

`default_nettype wire

//--- hw/warp_issue.sv
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------
// Warp issue stage with a round-robin pick
// ----------------------------------------

module warp_issue
    import gpu_pkg::*;
#(
    parameter int WARP_CNT = NUM_WARPS
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [WARP_CNT-1:0] warp_req,
    input  wire logic [WARP_CNT-1:0] warp_mem,
    input  wire logic                queue_full,
    output logic                     issue_valid,
    output wid_t                     issue_wid,
    output lane_e                    issue_lane
);

    wid_t last_wid;
    wid_t grant_wid;
    logic grant_found;
    logic grant_take;

    // Search the warps after the last grant in circular order
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_wid   = last_wid;
        for (int k = 1; k <= WARP_CNT; k++) begin
            idx = (int'(last_wid) + k) % WARP_CNT;
            if (!grant_found && warp_req[idx]) begin
                grant_found = 1'b1;
                grant_wid   = wid_t'(idx);
            end
        end
    end

    // A full queue holds every request where it is
    assign grant_take = grant_found && !queue_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
            // Start just before warp 0 so that it wins first
            last_wid    <= wid_t'(WARP_CNT - 1);
        end else begin
            issue_valid <= grant_take;
            if (grant_take) begin
                last_wid <= grant_wid;
            end
        end
    end

    // Lane of the granted warp, registered with the grant
    always_ff @(posedge clk) begin
        if (grant_take) begin
            issue_lane <= lane_e'(warp_mem[grant_wid]);
        end
    end

    // The last grant pointer is also the issued warp id
    assign issue_wid = last_wid;

endmodule

`default_nettype wire
